// File: files.f
hdl/rv_pkg.sv
hdl/decode_if.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/next_pc_unit.sv
hdl/regfile.sv
hdl/core_top.sv
verification/clock_gen.sv
verification/core_assertions.sv
verification/tb_top.sv

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
  decode_if.ex          ex,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  output rv_pkg::word_t alu_result
);

  rv_pkg::word_t op_b;
  logic [4:0]    shamt;
  logic          lt_s;
  logic          lt_u;

  assign op_b  = ex.use_imm ? ex.imm : rs2_data;
  assign shamt = op_b[4:0]; // only the low 5 bits count for shifts

  assign lt_s = $signed(rs1_data) < $signed(op_b);
  assign lt_u = rs1_data < op_b;

  always_comb begin
    case (ex.alu_op)
      rv_pkg::ALU_ADD:    alu_result = rs1_data + op_b;
      rv_pkg::ALU_SUB:    alu_result = rs1_data - op_b;
      rv_pkg::ALU_SLL:    alu_result = rs1_data << shamt;
      rv_pkg::ALU_SLT:    alu_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_s};
      rv_pkg::ALU_SLTU:   alu_result = {{(rv_pkg::XLEN-1){1'b0}}, lt_u};
      rv_pkg::ALU_XOR:    alu_result = rs1_data ^ op_b;
      rv_pkg::ALU_SRL:    alu_result = rs1_data >> shamt;
      rv_pkg::ALU_SRA:    alu_result = $signed(rs1_data) >>> shamt;
      rv_pkg::ALU_OR:     alu_result = rs1_data | op_b;
      rv_pkg::ALU_AND:    alu_result = rs1_data & op_b;
      rv_pkg::ALU_PASS_B: alu_result = op_b; // lui
      default:            alu_result = '0;
    endcase
  end

endmodule

// File: hdl/core_top.sv
`timescale 1ns/1ps

module core_top #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic             clk,
  input  logic             rst_n,
  output rv_pkg::word_t    pc,
  input  rv_pkg::word_t    instr,     // fetched combinationally from pc
  output logic             wb_en,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data
);

  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t link_addr;

  decode_if dif ();

  instr_decoder u_decoder (
    .instr (instr),
    .dec   (dif.dec)
  );

  alu u_alu (
    .ex         (dif.ex),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result)
  );

  next_pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_next_pc (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex        (dif.ex),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .pc        (pc),
    .link_addr (link_addr)
  );

  regfile u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb         (dif.wb),
    .alu_result (alu_result),
    .link_addr  (link_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

endmodule

// File: hdl/decode_if.sv
`timescale 1ns/1ps

interface decode_if;

  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [4:0]  rd;
  logic [31:0] imm;      // already sign-extended
  logic [3:0]  alu_op;
  logic        use_imm;  // immediate as alu operand b
  logic        reg_we;
  logic        wb_sel;
  logic        is_branch;
  logic        is_jal;
  logic        is_jalr;
  logic [2:0]  br_kind;

  modport dec (
    output rs1, rs2, rd, imm, alu_op, use_imm, reg_we, wb_sel,
    output is_branch, is_jal, is_jalr, br_kind
  );

  // alu and next-pc unit
  modport ex (
    input imm, alu_op, use_imm, is_branch, is_jal, is_jalr, br_kind
  );

  modport wb (
    input rs1, rs2, rd, reg_we, wb_sel
  );

endinterface

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
  input  rv_pkg::word_t instr,
  decode_if.dec         dec
);

  rv_pkg::instr_u iw;
  rv_pkg::word_t  i_imm;
  rv_pkg::word_t  b_imm;
  rv_pkg::word_t  u_imm;
  rv_pkg::word_t  j_imm;
  logic           base_f7;
  logic           alt_f7;

  function automatic rv_pkg::alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      rv_pkg::F3_ADD:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      rv_pkg::F3_SLL:  op = rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:  op = rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU: op = rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:  op = rv_pkg::ALU_XOR;
      rv_pkg::F3_SR:   op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:   op = rv_pkg::ALU_OR;
      default:         op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign iw = instr;

  assign dec.rs1     = iw.r_fmt.rs1;
  assign dec.rs2     = iw.r_fmt.rs2;
  assign dec.rd      = iw.r_fmt.rd;
  assign dec.br_kind = iw.b_fmt.funct3;

  assign i_imm = {{20{iw.i_fmt.imm_11_0[11]}}, iw.i_fmt.imm_11_0};
  assign b_imm = {{19{iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
                  iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
  assign u_imm = {iw.u_fmt.imm_31_12, 12'b0};
  assign j_imm = {{11{iw.j_fmt.imm_20}}, iw.j_fmt.imm_20, iw.j_fmt.imm_19_12,
                  iw.j_fmt.imm_11, iw.j_fmt.imm_10_1, 1'b0};

  assign base_f7 = (iw.r_fmt.funct7 == 7'b0);
  assign alt_f7  = (iw.r_fmt.funct7 == rv_pkg::F7_ALT);

  always_comb begin
    // unknown encodings fall through as no-ops
    dec.imm       = '0;
    dec.alu_op    = rv_pkg::ALU_ADD;
    dec.use_imm   = 1'b0;
    dec.reg_we    = 1'b0;
    dec.wb_sel    = rv_pkg::WB_ALU;
    dec.is_branch = 1'b0;
    dec.is_jal    = 1'b0;
    dec.is_jalr   = 1'b0;
    case (iw.r_fmt.opcode)
      rv_pkg::OP_REG: begin
        dec.alu_op = alu_from_f3(iw.r_fmt.funct3, alt_f7);
        // the alternate funct7 exists only for sub and sra
        dec.reg_we = base_f7 | (alt_f7 & ((iw.r_fmt.funct3 == rv_pkg::F3_ADD) |
                                          (iw.r_fmt.funct3 == rv_pkg::F3_SR)));
      end
      rv_pkg::OP_IMM: begin
        dec.imm     = i_imm;
        dec.use_imm = 1'b1;
        dec.alu_op  = alu_from_f3(iw.i_fmt.funct3, alt_f7 & (iw.i_fmt.funct3 == rv_pkg::F3_SR));
        case (iw.i_fmt.funct3)
          rv_pkg::F3_SLL: dec.reg_we = base_f7;
          rv_pkg::F3_SR:  dec.reg_we = base_f7 | alt_f7;
          default:        dec.reg_we = 1'b1;
        endcase
      end
      rv_pkg::OP_LUI: begin
        dec.imm     = u_imm;
        dec.use_imm = 1'b1;
        dec.alu_op  = rv_pkg::ALU_PASS_B;
        dec.reg_we  = 1'b1;
      end
      rv_pkg::OP_BRANCH: begin
        dec.imm = b_imm;
        case (iw.b_fmt.funct3)
          rv_pkg::BEQ, rv_pkg::BNE, rv_pkg::BLT,
          rv_pkg::BGE, rv_pkg::BLTU, rv_pkg::BGEU: dec.is_branch = 1'b1;
          default: dec.is_branch = 1'b0; // funct3 010/011 undefined
        endcase
      end
      rv_pkg::OP_JAL: begin
        dec.imm    = j_imm;
        dec.is_jal = 1'b1;
        dec.reg_we = 1'b1;
        dec.wb_sel = rv_pkg::WB_LINK;
      end
      rv_pkg::OP_JALR: begin
        if (iw.i_fmt.funct3 == 3'b000) begin
          dec.imm     = i_imm;
          dec.is_jalr = 1'b1;
          dec.reg_we  = 1'b1;
          dec.wb_sel  = rv_pkg::WB_LINK;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// File: hdl/next_pc_unit.sv
`timescale 1ns/1ps

module next_pc_unit #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst_n,
  decode_if.ex          ex,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t link_addr
);

  logic          taken;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t jalr_sum;
  rv_pkg::word_t pc_next;

  always_comb begin
    case (ex.br_kind)
      rv_pkg::BEQ:  taken = (rs1_data == rs2_data);
      rv_pkg::BNE:  taken = (rs1_data != rs2_data);
      rv_pkg::BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::BLTU: taken = (rs1_data < rs2_data);
      rv_pkg::BGEU: taken = (rs1_data >= rs2_data);
      default:      taken = 1'b0;
    endcase
  end

  assign pc_plus4  = pc + 32'd4;
  assign jalr_sum  = rs1_data + ex.imm;
  assign link_addr = pc_plus4; // return address for jal/jalr

  always_comb begin
    pc_next = pc_plus4;
    if (ex.is_jalr) begin
      pc_next = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0};
    end else if (ex.is_jal || (ex.is_branch && taken)) begin
      pc_next = pc + ex.imm;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next; // one instruction retires per edge
    end
  end

endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic             clk,
  input  logic             rst_n,
  decode_if.wb             wb,
  input  rv_pkg::word_t    alu_result,
  input  rv_pkg::word_t    link_addr,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  output logic             wb_en,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data
);

  rv_pkg::word_t regs [32];

  // asynchronous read ports
  // x0 is never written, so it keeps its reset value of zero
  assign rs1_data = regs[wb.rs1];
  assign rs2_data = regs[wb.rs2];

  // commit outputs describe the write at the next edge
  assign wb_en   = rst_n & wb.reg_we & (wb.rd != '0);
  assign wb_rd   = wb.rd;
  assign wb_data = (wb.wb_sel == rv_pkg::WB_LINK) ? link_addr : alu_result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_rd] <= wb_data;
    end
  end

endmodule

// File: hdl/rv_pkg.sv
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LUI    = 7'b0110111,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111
  } opcode_e;

  // funct3 for the register and immediate arithmetic groups
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // srl / sra
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_ALT = 7'b0100000; // sub, sra

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  // branch conditions, encoded as their funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_e;

  typedef enum logic {
    WB_ALU  = 1'b0,
    WB_LINK = 1'b1
  } wb_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, seen through each encoding format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

endpackage

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_top \
  --Mdir obj_dir -o sim_tb
status=0
output=$(./obj_dir/sim_tb 2>&1) || status=$?
echo "$output"
if [ "$status" -eq 0 ] && echo "$output" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// File: verification/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1; // released just after an edge
  end

endmodule

// File: verification/core_assertions.sv
`timescale 1ns/1ps

module core_assertions (
  input logic             clk,
  input logic             rst_n,
  input rv_pkg::word_t    pc,
  input logic             wb_en,
  input rv_pkg::reg_idx_t wb_rd
);

  a_pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  // x0 is never a write target
  a_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n) wb_en |-> wb_rd != '0)
    else $error("write enable raised for x0");

  a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !wb_en)
    else $error("write enable raised during reset");

endmodule

bind core_top core_assertions u_assertions (
  .clk   (clk),
  .rst_n (rst_n),
  .pc    (pc),
  .wb_en (wb_en),
  .wb_rd (wb_rd)
);

// File: verification/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam rv_pkg::word_t RESET_PC = 32'h0000_0100;
  localparam int RANDOM_COUNT  = 2000;
  localparam int RESET_TIMEOUT = 20;

  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  typedef struct packed {
    rv_pkg::word_t    next_pc;
    logic             wb_en;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::word_t    wb_data;
  } expect_t;

  logic             clk;
  logic             rst_n;
  rv_pkg::word_t    pc;
  rv_pkg::word_t    instr;
  logic             wb_en;
  rv_pkg::reg_idx_t wb_rd;
  rv_pkg::word_t    wb_data;

  rv_pkg::word_t imem [64];
  rv_pkg::word_t model_regs [32];
  rv_pkg::word_t model_pc;
  rv_pkg::word_t directed_q [$];
  logic [31:0]   lcg_state = 32'h5e19;

  clock_gen #(.PERIOD(4), .RESET_CYCLES(3)) u_clock_gen (.clk(clk), .rst_n(rst_n));

  core_top #(.RESET_PC(RESET_PC)) DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .pc      (pc),
    .instr   (instr),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  assign instr = imem[pc[7:2]]; // instruction memory, word indexed

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic rv_pkg::word_t enc_r(int f7, int f3, int rd, int rs1, int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_REG};
  endfunction

  function automatic rv_pkg::word_t enc_i(logic [6:0] opc, int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic rv_pkg::word_t enc_b(int f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic rv_pkg::word_t enc_u(int rd, int imm20);
    return {imm20[19:0], rd[4:0], OPC_LUI};
  endfunction

  function automatic rv_pkg::word_t enc_j(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
  endfunction

  // random word from the kept set, small aligned jumps
  function automatic rv_pkg::word_t rand_instr();
    logic [31:0] r;
    logic [31:0] s;
    int          f3;
    int          off;
    int          imm;
    r   = next_rand();
    s   = next_rand();
    f3  = int'(s[10:8]);
    off = (int'(s[2:0]) - 4) * 4;
    if (off >= 0) off += 4;
    imm = int'(s[31:20]);
    case (r[31:28])
      4'd0, 4'd1, 4'd2, 4'd3:
        return enc_r((s[7:4] == 4'd0) ? 1 : (s[3] ? 'h20 : 0), f3, int'(s[15:11]),
                     int'(s[20:16]), int'(s[25:21]));
      4'd4, 4'd5, 4'd6, 4'd7: begin
        if (f3 == 1 || f3 == 5) imm = (s[7:4] == 4'd0) ? 'h20 + (imm & 'h1f)
                                                        : (s[3] ? 'h400 : 0) + (imm & 'h1f);
        return enc_i(OPC_IMM, f3, int'(s[15:11]), int'(s[20:16]), imm);
      end
      4'd8:        return enc_u(int'(s[15:11]), int'(s[31:12]));
      4'd9, 4'd10, 4'd11:
        return enc_b(f3, int'(s[20:16]), int'(s[25:21]), off);
      4'd12:       return enc_j(int'(s[15:11]), off);
      4'd13:       return enc_i(OPC_JALR, (s[6:4] == 3'd7) ? 1 : 0, int'(s[15:11]), 0,
                                int'({s[31:26], 2'b00}));
      4'd14:       return {s[31:7], 7'b0001011}; // opcode outside the subset
      default:     return enc_i(OPC_IMM, 0, int'(s[15:11]), int'(s[20:16]), imm);
    endcase
  endfunction

  function automatic rv_pkg::word_t alu_ref(logic [2:0] f3, logic alt, rv_pkg::word_t a,
                                            rv_pkg::word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // one instruction of the ISA, from pc and the two source values
  function automatic expect_t ref_step(rv_pkg::word_t cur_pc, rv_pkg::word_t iw,
                                       rv_pkg::word_t a, rv_pkg::word_t b);
    expect_t       e;
    logic          we;
    logic          taken;
    logic [2:0]    f3;
    logic [6:0]    f7;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_j;
    f3        = iw[14:12];
    f7        = iw[31:25];
    imm_i     = {{20{iw[31]}}, iw[31:20]};
    imm_b     = {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
    imm_j     = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
    e.next_pc = cur_pc + 32'd4;
    e.wb_rd   = iw[11:7];
    e.wb_data = '0;
    we        = 1'b0;
    taken     = 1'b0;
    case (iw[6:0])
      OPC_REG: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          we        = 1'b1;
          e.wb_data = alu_ref(f3, f7[5], a, b);
        end
      end
      OPC_IMM: begin
        if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)) begin
          we        = 1'b1;
          e.wb_data = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
        end
      end
      OPC_LUI: begin
        we        = 1'b1;
        e.wb_data = {iw[31:12], 12'b0};
      end
      OPC_BRANCH: begin
        case (f3)
          3'd0:    taken = (a == b);
          3'd1:    taken = (a != b);
          3'd4:    taken = ($signed(a) < $signed(b));
          3'd5:    taken = ($signed(a) >= $signed(b));
          3'd6:    taken = (a < b);
          3'd7:    taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken) e.next_pc = cur_pc + imm_b;
      end
      OPC_JAL: begin
        we        = 1'b1;
        e.wb_data = cur_pc + 32'd4;
        e.next_pc = cur_pc + imm_j;
      end
      OPC_JALR: begin
        if (f3 == 3'd0) begin
          we        = 1'b1;
          e.wb_data = cur_pc + 32'd4;
          e.next_pc = (a + imm_i) & ~32'd1;
        end
      end
      default: begin
      end
    endcase
    e.wb_en = we && (e.wb_rd != 5'd0);
    return e;
  endfunction

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pc(input rv_pkg::word_t got, input rv_pkg::word_t exp);
    if (got !== exp)
      fail_stop($sformatf("mismatch at %0t: pc is %h, expected %h", $time, got, exp));
  endtask

  task automatic check_wb(input logic en_got, input rv_pkg::reg_idx_t rd_got,
                          input rv_pkg::word_t data_got, input logic en_exp,
                          input rv_pkg::reg_idx_t rd_exp, input rv_pkg::word_t data_exp);
    if (en_got !== en_exp)
      fail_stop($sformatf("mismatch at %0t: wb_en is %b, expected %b", $time, en_got, en_exp));
    else if (en_exp && (rd_got !== rd_exp || data_got !== data_exp))
      fail_stop($sformatf("mismatch at %0t: write x%0d=%h, expected x%0d=%h",
                          $time, rd_got, data_got, rd_exp, data_exp));
  endtask

  // stimulus: directed words placed at the live pc, then a random image
  initial begin
    int cnt;
    directed_q.push_back(enc_i(OPC_IMM, 0, 1, 0, 5));
    directed_q.push_back(enc_i(OPC_IMM, 0, 2, 0, -7));
    directed_q.push_back(enc_u(3, 'h80000));
    directed_q.push_back(enc_i(OPC_IMM, 0, 4, 0, -1));
    directed_q.push_back(enc_r(0, 0, 5, 1, 2));
    directed_q.push_back(enc_r('h20, 0, 6, 1, 2));  // sub
    directed_q.push_back(enc_r(0, 1, 7, 1, 1));
    directed_q.push_back(enc_r(0, 2, 8, 2, 1));     // slt, negative vs positive
    directed_q.push_back(enc_r(0, 3, 9, 2, 1));     // sltu, same operands
    directed_q.push_back(enc_r(0, 4, 10, 2, 4));
    directed_q.push_back(enc_r(0, 5, 11, 3, 1));
    directed_q.push_back(enc_r('h20, 5, 12, 3, 1)); // sra
    directed_q.push_back(enc_r(0, 6, 13, 1, 2));
    directed_q.push_back(enc_r(0, 7, 14, 1, 2));
    directed_q.push_back(enc_i(OPC_IMM, 2, 15, 2, 0));
    directed_q.push_back(enc_i(OPC_IMM, 3, 16, 2, 1));
    directed_q.push_back(enc_i(OPC_IMM, 5, 17, 4, 'h403)); // srai
    directed_q.push_back(enc_i(OPC_IMM, 5, 18, 3, 28));
    directed_q.push_back(enc_i(OPC_IMM, 1, 19, 1, 4));
    directed_q.push_back(enc_i(OPC_IMM, 4, 20, 2, 'h0f0));
    directed_q.push_back(enc_b(0, 1, 1, 8));    // beq taken
    directed_q.push_back(enc_b(0, 1, 2, 8));
    directed_q.push_back(enc_b(1, 1, 2, -12));  // bne taken, backwards
    directed_q.push_back(enc_b(1, 1, 1, 8));
    directed_q.push_back(enc_b(4, 2, 1, 12));
    directed_q.push_back(enc_b(4, 1, 2, 12));
    directed_q.push_back(enc_b(5, 2, 1, 8));
    directed_q.push_back(enc_b(5, 1, 2, 8));
    directed_q.push_back(enc_b(6, 2, 1, 8));
    directed_q.push_back(enc_b(6, 1, 2, -8));
    directed_q.push_back(enc_b(7, 2, 1, 16));
    directed_q.push_back(enc_b(7, 1, 2, 16));
    directed_q.push_back(enc_j(21, 16));
    directed_q.push_back(enc_j(22, -20));
    directed_q.push_back(enc_i(OPC_JALR, 0, 23, 1, 4));   // target 8, bit 0 cleared
    directed_q.push_back(enc_i(OPC_JALR, 0, 24, 0, 'h121));
    directed_q.push_back(enc_i(OPC_IMM, 0, 0, 1, 9));     // x0 target
    directed_q.push_back(enc_r(0, 0, 25, 0, 0));
    directed_q.push_back(enc_j(0, 8));
    directed_q.push_back(32'h0000_0000);
    directed_q.push_back(enc_r(1, 0, 26, 1, 2));
    directed_q.push_back(enc_i(OPC_IMM, 1, 27, 1, 'h404));
    directed_q.push_back(enc_b(2, 1, 1, 8));
    directed_q.push_back(enc_i(OPC_JALR, 1, 28, 1, 0));
    directed_q.push_back(32'hffff_ffff);
    for (int i = 0; i < 64; i++) imem[i] = '0;
    imem[RESET_PC[7:2]] = directed_q[0];
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (cnt > RESET_TIMEOUT) fail_stop("reset was never released");
    end while (!rst_n);
    for (int i = 1; i < directed_q.size(); i++) begin
      #1 imem[pc[7:2]] = directed_q[i];
      @(posedge clk);
    end
    #1;
    for (int i = 0; i < 64; i++) imem[i] = rand_instr();
  end

  // compare: sampled mid-cycle while the outputs are settled
  initial begin
    expect_t       e;
    rv_pkg::word_t iw;
    int            cycles;
    model_pc = RESET_PC;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) fail_stop("reset was never released");
      if (!rst_n) begin
        check_pc(pc, RESET_PC);
        check_wb(wb_en, wb_rd, wb_data, 1'b0, '0, '0);
      end
    end while (!rst_n);
    for (int n = 0; n < directed_q.size() + RANDOM_COUNT; n++) begin
      if (n > 0) @(negedge clk);
      iw = imem[model_pc[7:2]];
      e  = ref_step(model_pc, iw, model_regs[iw[19:15]], model_regs[iw[24:20]]);
      check_pc(pc, model_pc);
      check_wb(wb_en, wb_rd, wb_data, e.wb_en, e.wb_rd, e.wb_data);
      if (e.wb_en) model_regs[e.wb_rd] = e.wb_data;
      model_pc = e.next_pc;
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule
